// File: project.f
+incdir+hdl
hdl/tilt_pkg.sv
hdl/imu_scaler.sv
hdl/tilt_axis_filter.sv
hdl/filter_regs.sv
hdl/tilt_top.sv
verification/tilt_tb.sv

// File: verification/tilt_tb.sv
`default_nettype none

`include "tilt_config.svh"

module tilt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tilt_pkg::*;

    // run length, used for the timeout
    localparam int N_SAMPLES      = 49;
    localparam int N_WRITES       = 15;
    localparam int TIMEOUT_CYCLES = (N_SAMPLES + N_WRITES) * 4 + 200;

    logic        clk;
    logic        n_rst;
    logic        data_ready;
    logic        reg_wr;
    sample_t     accel_x_raw;
    sample_t     accel_y_raw;
    sample_t     accel_z_raw;
    sample_t     gyro_x_raw;
    sample_t     gyro_y_raw;
    reg_addr_t   reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    angle_t      tilt_pitch;
    angle_t      tilt_roll;
    logic        angle_valid;

    // model state
    angle_t      ref_pitch;
    angle_t      ref_roll;
    logic        ref_seed;
    step_t       shadow_dt;
    weight_t     shadow_pw;
    weight_t     shadow_rw;

    // expected {pitch, roll} and data_ready cycle, in sample order
    logic [31:0] exp_q[$];
    int          stamp_q[$];
    logic [31:0] exp_pair;
    int          issue_cycle;

    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          tests_failed = 0;
    int          test_errs_start = 0;

    tilt_top dut0 (
        .clk         (clk),
        .n_rst       (n_rst),
        .data_ready  (data_ready),
        .reg_wr      (reg_wr),
        .accel_x_raw (accel_x_raw),
        .accel_y_raw (accel_y_raw),
        .accel_z_raw (accel_z_raw),
        .gyro_x_raw  (gyro_x_raw),
        .gyro_y_raw  (gyro_y_raw),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .tilt_pitch  (tilt_pitch),
        .tilt_roll   (tilt_roll),
        .angle_valid (angle_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // cycle counter and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // accel angle, -lat/z in Q8.8 keeping the low 16 bits
    function automatic angle_t ref_accel_angle(input sample_t lat, input sample_t z);
        int num;
        int quot;
        num  = -(int'(lat) * 65536);
        quot = (num / int'(z)) >>> 8;
        return angle_t'(quot);
    endfunction

    // one axis update from the previous angle
    function automatic angle_t ref_axis(input angle_t prev, input logic seed,
                                        input sample_t lat, input sample_t z,
                                        input sample_t rate, input logic trusted,
                                        input step_t dt, input weight_t w);
        longint      delta;
        logic [15:0] delta_mid;
        angle_t      acc;
        angle_t      gyr;
        angle_t      blend;
        int          sum;
        acc = ref_accel_angle(lat, z);
        if (seed) begin
            return acc;
        end
        delta     = longint'(rate) * longint'(dt);
        delta_mid = delta[23:8];
        gyr       = angle_t'(prev - delta_mid);
        if (trusted) begin
            sum   = int'(gyr) * int'(w) + int'(acc) * (256 - int'(w));
            blend = angle_t'(sum >>> 8);
        end else begin
            blend = gyr;
        end
        // fold past the limit
        if (int'(blend) > `TILT_FOLD_LIMIT) begin
            blend = angle_t'(int'(blend) - `TILT_FOLD_LIMIT);
        end else if (int'(blend) < -`TILT_FOLD_LIMIT) begin
            blend = angle_t'(int'(blend) + `TILT_FOLD_LIMIT);
        end
        return blend;
    endfunction

    // full sample through the model, returns {pitch, roll}
    function automatic logic [31:0] model_sample(input sample_t axr, input sample_t ayr,
                                                 input sample_t azr, input sample_t gxr,
                                                 input sample_t gyr);
        sample_t ax;
        sample_t ay;
        sample_t az;
        sample_t gx;
        sample_t gy;
        int      mag;
        logic    trusted;
        ax = sample_t'(int'(axr) / `TILT_ACCEL_DIV);
        ay = sample_t'(int'(ayr) / `TILT_ACCEL_DIV);
        if (azr == 16'sd0) begin
            az = sample_t'(`TILT_AZ_DEFAULT);
        end else begin
            az = sample_t'(int'(azr) / `TILT_ACCEL_DIV);
        end
        gx = sample_t'((int'(gxr) * `TILT_GYRO_SCALE) / `TILT_GYRO_DIV);
        gy = sample_t'((int'(gyr) * `TILT_GYRO_SCALE) / `TILT_GYRO_DIV);
        mag     = int'(ax) * int'(ax) + int'(ay) * int'(ay) + int'(az) * int'(az);
        trusted = (mag >= `TILT_GSQ_MIN) && (mag <= `TILT_GSQ_MAX);
        // pitch uses accel x and gyro y, roll the other pair
        ref_pitch = ref_axis(ref_pitch, ref_seed, ax, az, gy, trusted, shadow_dt, shadow_pw);
        ref_roll  = ref_axis(ref_roll, ref_seed, ay, az, gx, trusted, shadow_dt, shadow_rw);
        ref_seed  = 1'b0;
        return {ref_pitch, ref_roll};
    endfunction

    task automatic check_angle(input string name, input angle_t expected, input angle_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %0d actual %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %0d actual %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // compare side, sampled mid-cycle
    always @(negedge clk) begin
        if (n_rst) begin
            if (data_ready) begin
                stamp_q.push_back(cycle_count);
            end
            if (angle_valid) begin
                if (exp_q.size() == 0) begin
                    $display("at %0t angle_valid pulsed with no sample outstanding", $time);
                    error_count++;
                end else begin
                    exp_pair    = exp_q.pop_front();
                    issue_cycle = (stamp_q.size() > 0) ? stamp_q.pop_front() : -1;
                    if (cycle_count - issue_cycle != 2) begin
                        $display("at %0t angle_valid came %0d cycles after data_ready, not 2",
                                 $time, cycle_count - issue_cycle);
                        error_count++;
                    end
                    check_angle("tilt_pitch", exp_pair[31:16], tilt_pitch);
                    check_angle("tilt_roll", exp_pair[15:0], tilt_roll);
                end
            end
        end
    end

    // one strobe, left high for the next call
    task automatic drive_sample(input sample_t axr, input sample_t ayr, input sample_t azr,
                                input sample_t gxr, input sample_t gyr);
        @(posedge clk);
        exp_q.push_back(model_sample(axr, ayr, azr, gxr, gyr));
        data_ready  <= 1'b1;
        accel_x_raw <= axr;
        accel_y_raw <= ayr;
        accel_z_raw <= azr;
        gyro_x_raw  <= gxr;
        gyro_y_raw  <= gyr;
    endtask

    // near 1 g, inside the trust window
    task automatic drive_level();
        drive_sample(sample_t'(rand_range(-1600, 1600)), sample_t'(rand_range(-1600, 1600)),
                     sample_t'(rand_range(8000, 8400)), sample_t'(rand_range(-2000, 2000)),
                     sample_t'(rand_range(-2000, 2000)));
    endtask

    // drop the strobe and wait for all results
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        data_ready <= 1'b0;
        while (exp_q.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("at %0t %0d samples never got angle_valid", $time, exp_q.size());
            error_count++;
            exp_q.delete();
            stamp_q.delete();
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
        // weights saturate at 256
        case (addr)
            REG_DT:      shadow_dt = data;
            REG_PITCH_W: shadow_pw = (data > 16'd256) ? 9'd256 : data[8:0];
            REG_ROLL_W:  shadow_rw = (data > 16'd256) ? 9'd256 : data[8:0];
            default:     ;
        endcase
    endtask

    task automatic read_reg(input reg_addr_t addr, input string name, input logic [15:0] exp);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        check_reg(name, exp, reg_rdata);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count != test_errs_start) begin
            tests_failed++;
        end
        $display("test %0d %s finished with %0d errors", test_count, name,
                 error_count - test_errs_start);
        test_errs_start = error_count;
    endtask

    initial begin
        int seed_value;
        seed_value  = $urandom(32'hbf6f);
        n_rst       = 1'b0;
        data_ready  = 1'b0;
        reg_wr      = 1'b0;
        accel_x_raw = '0;
        accel_y_raw = '0;
        accel_z_raw = '0;
        gyro_x_raw  = '0;
        gyro_y_raw  = '0;
        reg_addr    = REG_DT;
        reg_wdata   = '0;
        ref_pitch   = '0;
        ref_roll    = '0;
        ref_seed    = 1'b1;
        shadow_dt   = step_t'(`TILT_DT_RESET);
        shadow_pw   = weight_t'(`TILT_PITCH_W_RESET);
        shadow_rw   = weight_t'(`TILT_ROLL_W_RESET);
        repeat (10) @(posedge clk);
        n_rst <= 1'b1;

        // reset values, readback, clamp
        read_reg(REG_DT, "dt", 16'd58);
        read_reg(REG_PITCH_W, "pitch_weight", 16'd251);
        read_reg(REG_ROLL_W, "roll_weight", 16'd252);
        read_reg(REG_RSVD, "reg_rsvd", 16'd0);
        check_angle("tilt_pitch", 16'sd0, tilt_pitch);
        check_angle("tilt_roll", 16'sd0, tilt_roll);
        write_reg(REG_DT, 16'h1234);
        read_reg(REG_DT, "dt", 16'h1234);
        write_reg(REG_PITCH_W, 16'd300);
        read_reg(REG_PITCH_W, "pitch_weight", 16'd256);
        write_reg(REG_ROLL_W, 16'd100);
        read_reg(REG_ROLL_W, "roll_weight", 16'd100);
        write_reg(REG_DT, 16'd58);
        write_reg(REG_PITCH_W, 16'd251);
        write_reg(REG_ROLL_W, 16'd252);
        end_test("register readback");

        // seed from accel only
        drive_sample(16'sd1600, -16'sd960, 16'sd8192, 16'sd1500, -16'sd700);
        wait_idle();
        end_test("seed sample");

        // trusted blends, singles then a burst
        repeat (6) begin
            drive_level();
            wait_idle();
        end
        repeat (4) drive_level();
        wait_idle();
        end_test("level blend");

        // out of window and zero z
        drive_sample(16'sd16000, 16'sd0, 16'sd8192, 16'sd900, -16'sd1200);
        wait_idle();
        drive_sample(16'sd0, -16'sd16000, 16'sd8192, -16'sd400, 16'sd2500);
        wait_idle();
        drive_sample(16'sd320, 16'sd320, 16'sd4096, 16'sd100, 16'sd300);
        wait_idle();
        drive_sample(16'sd640, -16'sd320, 16'sd0, -16'sd1800, 16'sd600);
        wait_idle();
        drive_sample(16'sd0, 16'sd0, 16'sd0, 16'sd50, -16'sd50);
        wait_idle();
        drive_sample(16'sd12000, 16'sd3200, 16'sd0, 16'sd2200, 16'sd1700);
        wait_idle();
        end_test("untrusted and zero z");

        // large rates push past the fold limit
        repeat (20) begin
            drive_sample(($urandom % 2) ? 16'sd16000 : sample_t'(rand_range(-1600, 1600)),
                         sample_t'(rand_range(-1600, 1600)), 16'sd8192,
                         sample_t'(rand_range(-30000, 30000)),
                         sample_t'(rand_range(-30000, 30000)));
            wait_idle();
        end
        end_test("fold");

        // new dt and weights between samples
        write_reg(REG_DT, 16'd1000);
        write_reg(REG_PITCH_W, 16'd128);
        write_reg(REG_ROLL_W, 16'd200);
        repeat (4) begin
            drive_level();
            wait_idle();
        end
        write_reg(REG_DT, 16'd20000);
        write_reg(REG_PITCH_W, 16'd0);
        write_reg(REG_ROLL_W, 16'd256);
        repeat (4) begin
            drive_level();
            wait_idle();
        end
        write_reg(REG_DT, 16'd3);
        write_reg(REG_PITCH_W, 16'd400);
        write_reg(REG_ROLL_W, 16'd64);
        repeat (4) begin
            drive_level();
            wait_idle();
        end
        end_test("register update");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, tests_failed,
                 check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/tilt_top.sv
`default_nettype none

module tilt_top (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                data_ready,
    input  logic                reg_wr,
    input  tilt_pkg::sample_t   accel_x_raw,
    input  tilt_pkg::sample_t   accel_y_raw,
    input  tilt_pkg::sample_t   accel_z_raw,
    input  tilt_pkg::sample_t   gyro_x_raw,
    input  tilt_pkg::sample_t   gyro_y_raw,
    input  tilt_pkg::reg_addr_t reg_addr,
    input  logic [15:0]         reg_wdata,
    output logic [15:0]         reg_rdata,
    output tilt_pkg::angle_t    tilt_pitch,
    output tilt_pkg::angle_t    tilt_roll,
    output logic                angle_valid
);
    import tilt_pkg::*;

    // scaled sample, one cycle after data_ready
    sample_t accel_x;
    sample_t accel_y;
    sample_t accel_z;
    sample_t gyro_x;
    sample_t gyro_y;
    logic    accel_trusted;
    logic    scaled_valid;
    // control from the register block
    step_t   dt;
    weight_t pitch_weight;
    weight_t roll_weight;

    imu_scaler scaler0 (
        .clk           (clk),
        .n_rst         (n_rst),
        .data_ready    (data_ready),
        .accel_x_raw   (accel_x_raw),
        .accel_y_raw   (accel_y_raw),
        .accel_z_raw   (accel_z_raw),
        .gyro_x_raw    (gyro_x_raw),
        .gyro_y_raw    (gyro_y_raw),
        .accel_x       (accel_x),
        .accel_y       (accel_y),
        .accel_z       (accel_z),
        .gyro_x        (gyro_x),
        .gyro_y        (gyro_y),
        .accel_trusted (accel_trusted),
        .scaled_valid  (scaled_valid)
    );

    filter_regs regs0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .dt           (dt),
        .pitch_weight (pitch_weight),
        .roll_weight  (roll_weight)
    );

    // pitch from accel x, rotation about y
    tilt_axis_filter pitch_filter (
        .clk           (clk),
        .n_rst         (n_rst),
        .sample_valid  (scaled_valid),
        .accel_trusted (accel_trusted),
        .accel_lateral (accel_x),
        .accel_z       (accel_z),
        .gyro_rate     (gyro_y),
        .dt            (dt),
        .gyro_weight   (pitch_weight),
        .angle         (tilt_pitch),
        .angle_valid   (angle_valid)
    );

    // roll from accel y, rotation about x
    // its valid matches pitch, so it stays open
    tilt_axis_filter roll_filter (
        .clk           (clk),
        .n_rst         (n_rst),
        .sample_valid  (scaled_valid),
        .accel_trusted (accel_trusted),
        .accel_lateral (accel_y),
        .accel_z       (accel_z),
        .gyro_rate     (gyro_x),
        .dt            (dt),
        .gyro_weight   (roll_weight),
        .angle         (tilt_roll),
        .angle_valid   ()
    );

endmodule

`default_nettype wire

// File: hdl/filter_regs.sv
`default_nettype none

`include "tilt_config.svh"

module filter_regs (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                reg_wr,
    input  tilt_pkg::reg_addr_t reg_addr,
    input  logic [15:0]         reg_wdata,
    output logic [15:0]         reg_rdata,
    output tilt_pkg::step_t     dt,
    output tilt_pkg::weight_t   pitch_weight,
    output tilt_pkg::weight_t   roll_weight
);
    import tilt_pkg::*;

    // saturate a written weight at 1.0
    function automatic weight_t clamp_weight(input logic [15:0] value);
        weight_t result;
        if (value > 16'(WEIGHT_ONE)) begin
            result = WEIGHT_ONE;
        end else begin
            result = weight_t'(value);
        end
        return result;
    endfunction

    // write port, takes effect at the edge
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dt           <= step_t'(`TILT_DT_RESET);
            pitch_weight <= weight_t'(`TILT_PITCH_W_RESET);
            roll_weight  <= weight_t'(`TILT_ROLL_W_RESET);
        end else if (reg_wr) begin
            case (reg_addr)
                REG_DT: begin
                    dt <= reg_wdata;
                end
                REG_PITCH_W: begin
                    pitch_weight <= clamp_weight(reg_wdata);
                end
                REG_ROLL_W: begin
                    roll_weight <= clamp_weight(reg_wdata);
                end
                REG_RSVD: begin
                    // nothing behind this address
                end
                default: begin
                end
            endcase
        end
    end

    // combinational readback, zero-extended
    always_comb begin
        case (reg_addr)
            REG_DT: begin
                reg_rdata = dt;
            end
            REG_PITCH_W: begin
                reg_rdata = 16'(pitch_weight);
            end
            REG_ROLL_W: begin
                reg_rdata = 16'(roll_weight);
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

    // filters rely on weights within 0..256
    a_weights_clamped: assert property (
        @(posedge clk) disable iff (!n_rst)
        (pitch_weight <= WEIGHT_ONE) && (roll_weight <= WEIGHT_ONE)
    ) else $error("weight register above full scale");

endmodule

`default_nettype wire

// File: hdl/tilt_axis_filter.sv
`default_nettype none

`include "tilt_config.svh"

module tilt_axis_filter (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              sample_valid,
    input  logic              accel_trusted,
    input  tilt_pkg::sample_t accel_lateral,
    input  tilt_pkg::sample_t accel_z,
    input  tilt_pkg::sample_t gyro_rate,
    input  tilt_pkg::step_t   dt,
    input  tilt_pkg::weight_t gyro_weight,
    output tilt_pkg::angle_t  angle,
    output logic              angle_valid
);
    import tilt_pkg::*;

    // accel angle path
    logic signed [31:0] lat_ext;
    logic signed [31:0] z_ext;
    logic signed [31:0] accel_num;
    logic signed [31:0] accel_quot;
    angle_t             accel_angle;
    // gyro integration path
    logic signed [32:0] gyro_delta;
    angle_t             gyro_angle;
    // blend weights as signed operands
    logic signed [9:0]  w_gyro;
    logic signed [9:0]  w_accel;
    logic signed [25:0] blend_sum;
    angle_t             blend;
    angle_t             folded;
    // first sample after reset seeds from accel
    logic               seed;

    // sign-extend both operands of the divide
    assign lat_ext = 32'(accel_lateral);
    assign z_ext   = 32'(accel_z);

    // -lateral / z in Q16, then back down to Q8.8
    // |lateral| <= 1024 keeps the shift inside 32 bits
    assign accel_num   = -(lat_ext <<< 16);
    assign accel_quot  = (accel_num / z_ext) >>> 8;
    assign accel_angle = accel_quot[15:0];

    // rate times dt, dt zero-extended as unsigned Q0.16
    assign gyro_delta = gyro_rate * $signed({1'b0, dt});
    // drop 8 fraction bits and integrate
    assign gyro_angle = angle - angle_t'(gyro_delta[23:8]);

    // accel weight is the complement to 256
    assign w_gyro  = $signed({1'b0, gyro_weight});
    assign w_accel = $signed({1'b0, WEIGHT_ONE}) - w_gyro;

    // weighted sum, at most about 2^24 in magnitude
    assign blend_sum = (gyro_angle * w_gyro) + (accel_angle * w_accel);

    // untrusted accel means gyro only
    assign blend = accel_trusted ? angle_t'(blend_sum >>> 8) : gyro_angle;

    // fold back past the limit
    always_comb begin
        if (blend > `TILT_FOLD_LIMIT) begin
            folded = angle_t'(blend - `TILT_FOLD_LIMIT);
        end else if (blend < -`TILT_FOLD_LIMIT) begin
            folded = angle_t'(blend + `TILT_FOLD_LIMIT);
        end else begin
            folded = blend;
        end
    end

    // angle state, doubles as the output
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            angle       <= '0;
            seed        <= 1'b1;
            angle_valid <= 1'b0;
        end else begin
            // result visible together with the pulse
            angle_valid <= sample_valid;
            if (sample_valid) begin
                if (seed) begin
                    // no history yet, take accel as is
                    angle <= accel_angle;
                    seed  <= 1'b0;
                end else begin
                    angle <= folded;
                end
            end
        end
    end

    // register block must keep the weight in range
    a_weight_range: assert property (
        @(posedge clk) disable iff (!n_rst)
        gyro_weight <= WEIGHT_ONE
    ) else $error("gyro_weight %0d above full scale", gyro_weight);

endmodule

`default_nettype wire

// File: hdl/imu_scaler.sv
`default_nettype none

`include "tilt_config.svh"

module imu_scaler (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              data_ready,
    input  tilt_pkg::sample_t accel_x_raw,
    input  tilt_pkg::sample_t accel_y_raw,
    input  tilt_pkg::sample_t accel_z_raw,
    input  tilt_pkg::sample_t gyro_x_raw,
    input  tilt_pkg::sample_t gyro_y_raw,
    output tilt_pkg::sample_t accel_x,
    output tilt_pkg::sample_t accel_y,
    output tilt_pkg::sample_t accel_z,
    output tilt_pkg::sample_t gyro_x,
    output tilt_pkg::sample_t gyro_y,
    output logic              accel_trusted,
    output logic              scaled_valid
);
    import tilt_pkg::*;

    // combinational scaled values
    sample_t            ax_s;
    sample_t            ay_s;
    sample_t            az_s;
    sample_t            gx_s;
    sample_t            gy_s;
    // gyro products before the divide
    logic signed [31:0] gx_prod;
    logic signed [31:0] gy_prod;
    // squared magnitude terms
    logic signed [31:0] ax_sq;
    logic signed [31:0] ay_sq;
    logic signed [31:0] az_sq;
    logic signed [31:0] mag_sq;
    logic               trusted_c;

    // accel counts to 1/256 g, truncating toward zero
    assign ax_s = sample_t'(accel_x_raw / `TILT_ACCEL_DIV);
    assign ay_s = sample_t'(accel_y_raw / `TILT_ACCEL_DIV);
    // zero z would break the angle divide downstream
    assign az_s = (accel_z_raw == '0) ? sample_t'(`TILT_AZ_DEFAULT)
                                      : sample_t'(accel_z_raw / `TILT_ACCEL_DIV);

    // gyro scale in 32 bits, max product well below 2^31
    assign gx_prod = gyro_x_raw * `TILT_GYRO_SCALE;
    assign gy_prod = gyro_y_raw * `TILT_GYRO_SCALE;
    assign gx_s    = sample_t'(gx_prod / `TILT_GYRO_DIV);
    assign gy_s    = sample_t'(gy_prod / `TILT_GYRO_DIV);

    // |a|^2 of the scaled vector
    // each term at most about 2^20 so no overflow
    assign ax_sq  = ax_s * ax_s;
    assign ay_sq  = ay_s * ay_s;
    assign az_sq  = az_s * az_s;
    assign mag_sq = ax_sq + ay_sq + az_sq;

    // trust accel only near 1 g
    assign trusted_c = (mag_sq >= `TILT_GSQ_MIN) && (mag_sq <= `TILT_GSQ_MAX);

    // strobe pipeline
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            scaled_valid <= 1'b0;
        end else begin
            scaled_valid <= data_ready;
        end
    end

    // sample payload, captured on the strobe
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            accel_x       <= '0;
            accel_y       <= '0;
            accel_z       <= '0;
            gyro_x        <= '0;
            gyro_y        <= '0;
            accel_trusted <= 1'b0;
        end else if (data_ready) begin
            accel_x       <= ax_s;
            accel_y       <= ay_s;
            accel_z       <= az_s;
            gyro_x        <= gx_s;
            gyro_y        <= gy_s;
            accel_trusted <= trusted_c;
        end
    end

    // back-to-back valid only from back-to-back strobes
    a_valid_from_strobe: assert property (
        @(posedge clk) disable iff (!n_rst)
        (scaled_valid && $past(scaled_valid)) |-> ($past(data_ready, 1) && $past(data_ready, 2))
    ) else $error("scaled_valid held high without two data_ready strobes");

endmodule

`default_nettype wire

// File: hdl/tilt_pkg.sv
`default_nettype none

package tilt_pkg;

    // raw or scaled sensor word
    typedef logic signed [15:0] sample_t;

    // tilt angle, Q8.8 degrees
    typedef logic signed [15:0] angle_t;

    // blend weight in 1/256 steps, 0 to 256
    typedef logic [8:0] weight_t;

    // integration step, Q0.16 seconds
    typedef logic [15:0] step_t;

    // register map of the filter control block
    typedef enum logic [1:0] {
        REG_DT      = 2'd0,
        REG_PITCH_W = 2'd1,
        REG_ROLL_W  = 2'd2,
        // unmapped, reads zero
        REG_RSVD    = 2'd3
    } reg_addr_t;

    // full weight, i.e. 1.0 in 1/256 steps
    localparam weight_t WEIGHT_ONE = 9'd256;

endpackage

`default_nettype wire

// File: hdl/tilt_config.svh
`ifndef TILT_CONFIG_SVH
`define TILT_CONFIG_SVH

// raw accel counts to 1/256 g units
`define TILT_ACCEL_DIV 32

// gyro counts to Q8.8 deg/s
// multiply first, then signed truncating divide
`define TILT_GYRO_SCALE 1000
`define TILT_GYRO_DIV 16768

// substitute for an accel z reading of exactly zero
`define TILT_AZ_DEFAULT 256

// squared magnitude window for a trusted accelerometer
// roughly 0.8 g^2 and 1.2 g^2, both edges inclusive
`define TILT_GSQ_MIN 52428
`define TILT_GSQ_MAX 78643

// wrap distance applied when an angle leaves +/- limit
`define TILT_FOLD_LIMIT 70

// register block reset values
// dt in Q0.16 seconds, about 0.89 ms
`define TILT_DT_RESET 58
// gyro weights in 1/256 steps
`define TILT_PITCH_W_RESET 251
`define TILT_ROLL_W_RESET 252

`endif
